//--- sim.f
msx_cart_pkg.sv
mux_bus_sampler.sv
sd_host_regs.sv
sd_sector_buffer.sv
mapper_config_port.sv
bus_return.sv
msx_cart_top.sv
tb_msx_cart.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_msx_cart -f sim.f -Mdir obj_dir -o tb_msx_cart

# the log decides the result, so a failing run must not stop the script here
./obj_dir/tb_msx_cart > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_msx_cart.sv
`timescale 1ns/1ns

module tb_msx_cart;

    typedef enum logic [1:0] {MEM_RD, MEM_WR, IO_WR} cyc_kind_e;

    logic                      clk108_w = 1'b0;
    logic                      ram_enabled_w;
    logic [7:0]                mp;
    logic                      rd_n;
    logic                      wr_n;
    logic                      sltsl_n;
    logic [7:0]                cd_in;
    msx_cart_pkg::sd_stat_t    sd_stat;
    logic [2:0]                msel_n;
    logic [7:0]                cd_out;
    logic                      data_dir;
    msx_cart_pkg::sd_req_t     sd_req;
    msx_cart_pkg::mapper_cfg_t mapper_cfg;

    logic [15:0]              cur_addr;   // address the bus model puts on mp
    msx_cart_pkg::ctrl_byte_t cur_ctrl;
    int                       cyc = 0;    // clocks since reset release
    int                       strobe_cyc;
    integer                   seed = 3;

    msx_cart_top u_msx_cart_top (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .cd_in         (cd_in),
        .sd_stat       (sd_stat),
        .msel_n        (msel_n),
        .cd_out        (cd_out),
        .data_dir      (data_dir),
        .sd_req        (sd_req),
        .mapper_cfg    (mapper_cfg)
    );

    always #4 clk108_w = ~clk108_w;

    always @(posedge clk108_w) begin
        if (ram_enabled_w)
            cyc <= cyc + 1;
    end

    // external multiplexer
    initial begin
        mp = 8'hFF;
        forever begin
            @(posedge clk108_w);
            #1;
            case (msel_n)
                msx_cart_pkg::MSEL_LOW:  mp = cur_addr[7:0];
                msx_cart_pkg::MSEL_HIGH: mp = cur_addr[15:8];
                msx_cart_pkg::MSEL_CTRL: mp = cur_ctrl;
                default:                 mp = 8'hFF;
            endcase
        end
    end

    initial begin : watchdog
        int limit_ns;
        limit_ns = 6 * 60 * msx_cart_pkg::BUS_FRAME * 8;  // six tests
        #(limit_ns);
        $display("simulation timed out after %0d ns", limit_ns);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // checks
    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_sel(input logic [2:0] exp, input string what);
        if (msel_n !== exp)
            report_mismatch($sformatf("%s: msel_n %b expected %b", what, msel_n, exp));
    endtask

    // cd_out only matters while the cartridge drives the bus
    task automatic check_byte(input logic [7:0] exp_data, input logic exp_dir,
                              input string what);
        if (data_dir !== exp_dir)
            report_mismatch($sformatf("%s: data_dir %b expected %b", what, data_dir, exp_dir));
        else if (!exp_dir && cd_out !== exp_data)
            report_mismatch($sformatf("%s: cd_out %h expected %h", what, cd_out, exp_data));
    endtask

    task automatic check_req(input msx_cart_pkg::sd_req_t exp, input string what);
        if (sd_req !== exp)
            report_mismatch($sformatf("%s: sd_req %h expected %h", what, sd_req, exp));
    endtask

    task automatic check_cfg(input msx_cart_pkg::mapper_cfg_t exp, input string what);
        if (mapper_cfg !== exp)
            report_mismatch($sformatf("%s: mapper_cfg %h expected %h", what, mapper_cfg, exp));
    endtask

    ////////////////////
    // bus model
    function automatic logic [2:0] expected_sel(input int k);
        case (k % msx_cart_pkg::BUS_FRAME)
            1, 2:    return msx_cart_pkg::MSEL_LOW;
            3, 4:    return msx_cart_pkg::MSEL_HIGH;
            5, 6:    return msx_cart_pkg::MSEL_CTRL;
            default: return msx_cart_pkg::MSEL_NONE;
        endcase
    endfunction

    task automatic wait_frame_start();
        @(posedge clk108_w);
        #1;
        while (cyc % msx_cart_pkg::BUS_FRAME != 1) begin  // msel_n just went to low byte
            @(posedge clk108_w);
            #1;
        end
    endtask

    task automatic wait_to_cycle(input int n);
        while (cyc < n) begin
            @(posedge clk108_w);
            #1;
        end
    endtask

    task automatic cpu_cycle(input logic [15:0] addr, input logic [7:0] data,
                             input cyc_kind_e kind);
        msx_cart_pkg::ctrl_byte_t ctrl;
        ctrl = '1;
        if (kind == IO_WR)
            ctrl.iorq_n = 1'b0;
        else
            ctrl.merq_n = 1'b0;
        wait_frame_start();
        cur_addr   = addr;
        cur_ctrl   = ctrl;
        cd_in      = data;
        rd_n       = (kind != MEM_RD);
        wr_n       = (kind == MEM_RD);
        sltsl_n    = (kind == IO_WR);  // no slot select on io
        strobe_cyc = cyc + msx_cart_pkg::BUS_FRAME - 1;
        wait_frame_start();
        cur_addr = 16'hFFFF;  // back to idle
        cur_ctrl = '1;
        cd_in    = 8'hFF;
        rd_n     = 1'b1;
        wr_n     = 1'b1;
        sltsl_n  = 1'b1;
    endtask

    task automatic mem_read_check(input logic [15:0] addr, input logic [7:0] exp_data,
                                  input logic exp_dir, input string what);
        cpu_cycle(addr, 8'hFF, MEM_RD);
        wait_to_cycle(strobe_cyc + 2);  // return path lags the strobe by two clocks
        check_byte(exp_data, exp_dir, what);
    endtask

    ////////////////////
    // directed tests
    task automatic test_reset_state();
        msx_cart_pkg::sd_req_t exp_req;
        exp_req = '0;
        check_sel(msx_cart_pkg::MSEL_NONE, "reset msel_n");
        check_byte(8'h00, 1'b1, "reset data_dir");
        check_req(exp_req, "reset sd_req");
        check_cfg('{megaram_type: msx_cart_pkg::MR_SCC, scc_enable: 1'b1}, "reset cfg");
        ram_enabled_w = 1'b1;
        for (int i = 0; i < 2 * msx_cart_pkg::BUS_FRAME; i++) begin
            @(posedge clk108_w);
            #1;
            check_sel(expected_sel(cyc), $sformatf("select sequence clock %0d", cyc));
        end
    endtask

    task automatic test_enable_gating();
        mem_read_check(msx_cart_pkg::SDC_SDATA + 16'd5, 8'h00, 1'b1, "buffer before enable");
        cpu_cycle(msx_cart_pkg::SDC_ENABLE, 8'h01, MEM_WR);
        mem_read_check(msx_cart_pkg::SDC_ENABLE, 8'h01, 1'b0, "enable readback");
    endtask

    task automatic test_sector_buffer();
        logic [7:0] model [msx_cart_pkg::SECTOR_BYTES];
        logic [8:0] offs [8];
        logic [7:0] val;
        for (int i = 0; i < 8; i++) begin
            offs[i]        = 9'($random(seed));
            val            = 8'($random(seed));
            model[offs[i]] = val;  // a repeated offset keeps the last byte
            cpu_cycle(msx_cart_pkg::SDC_SDATA + {7'b0, offs[i]}, val, MEM_WR);
        end
        for (int i = 0; i < 8; i++) begin
            mem_read_check(msx_cart_pkg::SDC_SDATA + {7'b0, offs[i]}, model[offs[i]], 1'b0,
                           $sformatf("buffer offset %0d", offs[i]));
        end
        mem_read_check(16'h4000, 8'h00, 1'b1, "unmapped read");
    endtask

    task automatic test_command_sector();
        msx_cart_pkg::sd_req_t exp_req;
        logic [31:0]           sector;
        exp_req = '0;
        sector  = $random(seed);
        for (int i = 0; i < 4; i++)
            cpu_cycle(msx_cart_pkg::SDC_SADDR + 16'(i), sector[8*i +: 8], MEM_WR);
        exp_req.sector = sector;  // lsb first
        check_req(exp_req, "sector address");
        cpu_cycle(msx_cart_pkg::SDC_CMD, 8'h01, MEM_WR);
        exp_req.read_start = 1'b1;
        check_req(exp_req, "read command");
        @(posedge clk108_w);
        #1;
        sd_stat.done = 1'b1;
        @(posedge clk108_w);
        #1;
        sd_stat.done = 1'b0;
        exp_req.read_start = 1'b0;
        check_req(exp_req, "done clears read");
        cpu_cycle(msx_cart_pkg::SDC_CMD, 8'h80, MEM_WR);
        exp_req.init = 1'b1;
        check_req(exp_req, "init command");
    endtask

    task automatic test_status_readback();
        sd_stat = '{busy: 1'b1, done: 1'b0, crc_error: 1'b1, timeout_error: 1'b0,
                    card_type: 2'd2};
        mem_read_check(msx_cart_pkg::SDC_STATUS, 8'h81, 1'b0, "status");
        mem_read_check(msx_cart_pkg::SDC_CTYPE, 8'h02, 1'b0, "card type");
        mem_read_check(16'h7E20, 8'hFF, 1'b0, "unused register");
        sd_stat = '0;
    endtask

    task automatic test_mapper_config();
        cpu_cycle(16'h008F, 8'h16, IO_WR);
        check_cfg('{megaram_type: msx_cart_pkg::MR_ASCII16, scc_enable: 1'b0}, "ascii16");
        cpu_cycle(16'h008F, 8'h08, IO_WR);
        check_cfg('{megaram_type: msx_cart_pkg::MR_ASCII8, scc_enable: 1'b0}, "ascii8");
        cpu_cycle(16'h008F, 8'h04, IO_WR);
        check_cfg('{megaram_type: msx_cart_pkg::MR_KONAMI, scc_enable: 1'b0}, "konami");
        cpu_cycle(16'h008F, 8'h05, IO_WR);
        check_cfg('{megaram_type: msx_cart_pkg::MR_SCC, scc_enable: 1'b1}, "konami scc");
        cpu_cycle(16'h008F, 8'h33, IO_WR);
        check_cfg('{megaram_type: msx_cart_pkg::MR_SCC, scc_enable: 1'b1}, "unknown code");
        cpu_cycle(16'h008F, 8'h16, MEM_WR);
        check_cfg('{megaram_type: msx_cart_pkg::MR_SCC, scc_enable: 1'b1}, "memory write");
    endtask

    initial begin
        ram_enabled_w = 1'b0;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        sltsl_n       = 1'b1;
        cd_in         = 8'hFF;
        sd_stat       = '0;
        cur_addr      = 16'hFFFF;
        cur_ctrl      = '1;
        repeat (16) @(posedge clk108_w);
        #1;
        test_reset_state();
        test_enable_gating();
        test_sector_buffer();
        test_command_sector();
        test_status_readback();
        test_mapper_config();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- msx_cart_top.sv
`timescale 1ns/1ns

module msx_cart_top (
    input  logic                      clk108_w,
    input  logic                      ram_enabled_w,
    input  logic [7:0]                mp,
    input  logic                      rd_n,
    input  logic                      wr_n,
    input  logic                      sltsl_n,
    input  logic [7:0]                cd_in,
    input  msx_cart_pkg::sd_stat_t    sd_stat,
    output logic [2:0]                msel_n,
    output logic [7:0]                cd_out,
    output logic                      data_dir,
    output msx_cart_pkg::sd_req_t     sd_req,
    output msx_cart_pkg::mapper_cfg_t mapper_cfg
);

    msx_cart_pkg::cpu_bus_t    bus;
    logic                      bus_strobe;
    logic                      sd_en;
    msx_cart_pkg::slave_resp_t reg_resp;
    msx_cart_pkg::slave_resp_t buf_resp;

    mux_bus_sampler u_mux_bus_sampler (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .cd_in         (cd_in),
        .msel_n        (msel_n),
        .bus           (bus),
        .bus_strobe    (bus_strobe)
    );

    ////////////////////
    // bus slaves
    sd_host_regs u_sd_host_regs (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus),
        .bus_strobe    (bus_strobe),
        .sd_stat       (sd_stat),
        .reg_resp      (reg_resp),
        .sd_en         (sd_en),
        .sd_req        (sd_req)
    );

    sd_sector_buffer u_sd_sector_buffer (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus),
        .bus_strobe    (bus_strobe),
        .sd_en         (sd_en),
        .buf_resp      (buf_resp)
    );

    mapper_config_port u_mapper_config_port (  // write only, no response
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus),
        .bus_strobe    (bus_strobe),
        .mapper_cfg    (mapper_cfg)
    );

    bus_return u_bus_return (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .reg_resp      (reg_resp),
        .buf_resp      (buf_resp),
        .cd_out        (cd_out),
        .data_dir      (data_dir)
    );

endmodule

//--- bus_return.sv
`timescale 1ns/1ns

module bus_return (
    input  logic                      clk108_w,
    input  logic                      ram_enabled_w,
    input  msx_cart_pkg::slave_resp_t reg_resp,
    input  msx_cart_pkg::slave_resp_t buf_resp,
    output logic [7:0]                cd_out,
    output logic                      data_dir
);

    logic       resp_hit;
    logic [7:0] resp_data;

    // windows never overlap, so at most one hit
    assign resp_hit  = reg_resp.hit || buf_resp.hit;
    assign resp_data = reg_resp.hit ? reg_resp.data : buf_resp.data;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            data_dir <= 1'b1;       // bus input
        else
            data_dir <= !resp_hit;  // low drives cd toward the cpu
    end

    always_ff @(posedge clk108_w) begin
        if (resp_hit)
            cd_out <= resp_data;
    end

endmodule

//--- mapper_config_port.sv
`timescale 1ns/1ns

module mapper_config_port (
    input  logic                      clk108_w,
    input  logic                      ram_enabled_w,
    input  msx_cart_pkg::cpu_bus_t    bus,
    input  logic                      bus_strobe,
    output msx_cart_pkg::mapper_cfg_t mapper_cfg
);

    logic cfg_wr;

    // io write to port 8fh, low address byte only
    assign cfg_wr = bus_strobe && !bus.iorq_n && bus.m1_n && !bus.wr_n && bus.rd_n &&
                    (bus.addr[7:0] == msx_cart_pkg::CFG_PORT);

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_cfg <= '{megaram_type: msx_cart_pkg::MR_SCC, scc_enable: 1'b1};
        end else if (cfg_wr) begin
            case (bus.data)
                msx_cart_pkg::CFG_KONAMI_SCC: begin
                    mapper_cfg <= '{megaram_type: msx_cart_pkg::MR_SCC, scc_enable: 1'b1};
                end
                msx_cart_pkg::CFG_ASCII16: begin
                    mapper_cfg <= '{megaram_type: msx_cart_pkg::MR_ASCII16, scc_enable: 1'b0};
                end
                msx_cart_pkg::CFG_ASCII8: begin
                    mapper_cfg <= '{megaram_type: msx_cart_pkg::MR_ASCII8, scc_enable: 1'b0};
                end
                msx_cart_pkg::CFG_KONAMI: begin
                    mapper_cfg <= '{megaram_type: msx_cart_pkg::MR_KONAMI, scc_enable: 1'b0};
                end
                default: ;  // unknown code, keep current mapper
            endcase
        end
    end

endmodule

//--- sd_sector_buffer.sv
`timescale 1ns/1ns

module sd_sector_buffer (
    input  logic                      clk108_w,
    input  logic                      ram_enabled_w,
    input  msx_cart_pkg::cpu_bus_t    bus,
    input  logic                      bus_strobe,
    input  logic                      sd_en,
    output msx_cart_pkg::slave_resp_t buf_resp
);

    logic [7:0] mem [msx_cart_pkg::SECTOR_BYTES];
    logic [8:0] idx;
    logic       claim;
    logic       hit_q;
    logic [7:0] data_q;

    assign idx   = bus.addr[8:0];  // offset inside the 512 byte window
    assign claim = sd_en && !bus.merq_n && bus.iorq_n && bus.m1_n && !bus.sltsl_n &&
                   (bus.addr >= msx_cart_pkg::SDC_SDATA) &&
                   (bus.addr <= msx_cart_pkg::SDC_SDATA_END);

    always_ff @(posedge clk108_w) begin
        if (bus_strobe) begin
            if (claim && !bus.wr_n)
                mem[idx] <= bus.data;
            data_q <= mem[idx];
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            hit_q <= 1'b0;
        else if (bus_strobe)
            hit_q <= claim && !bus.rd_n;  // held for the whole frame
    end

    assign buf_resp = '{hit: hit_q, data: data_q};

endmodule

//--- sd_host_regs.sv
`timescale 1ns/1ns

module sd_host_regs (
    input  logic                      clk108_w,
    input  logic                      ram_enabled_w,
    input  msx_cart_pkg::cpu_bus_t    bus,
    input  logic                      bus_strobe,
    input  msx_cart_pkg::sd_stat_t    sd_stat,
    output msx_cart_pkg::slave_resp_t reg_resp,
    output logic                      sd_en,
    output msx_cart_pkg::sd_req_t     sd_req
);

    logic       mem_cyc;
    logic       in_win;
    logic       is_enable;
    logic       claim;
    logic [7:0] rd_data;

    assign mem_cyc   = !bus.merq_n && bus.iorq_n && bus.m1_n && !bus.sltsl_n;
    assign in_win    = (bus.addr >= msx_cart_pkg::SDC_ENABLE) &&
                       (bus.addr <= msx_cart_pkg::SDC_END);
    assign is_enable = (bus.addr == msx_cart_pkg::SDC_ENABLE);
    assign claim     = mem_cyc && in_win && (sd_en || is_enable);  // enable reg always open

    // readback mux
    always_comb begin
        case (bus.addr)
            msx_cart_pkg::SDC_ENABLE: rd_data = {7'b0, sd_en};
            msx_cart_pkg::SDC_STATUS: begin
                rd_data = {sd_stat.busy, 5'b0, sd_stat.timeout_error, sd_stat.crc_error};
            end
            msx_cart_pkg::SDC_CTYPE:  rd_data = {6'b0, sd_stat.card_type};
            default:                  rd_data = 8'hFF;
        endcase
    end

    ////////////////////
    // register writes and read response
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en    <= 1'b0;
            sd_req   <= '0;
            reg_resp <= '0;
        end else begin
            if (sd_stat.done) begin  // card finished, drop the request
                sd_req.read_start  <= 1'b0;
                sd_req.write_start <= 1'b0;
            end
            if (bus_strobe) begin
                reg_resp.hit  <= claim && !bus.rd_n;
                reg_resp.data <= rd_data;
                if (claim && !bus.wr_n) begin
                    case (bus.addr)
                        msx_cart_pkg::SDC_ENABLE: sd_en <= bus.data[0];
                        msx_cart_pkg::SDC_CMD: begin
                            sd_req.read_start  <= sd_req.read_start | bus.data[0];
                            sd_req.write_start <= sd_req.write_start | bus.data[1];
                            sd_req.init        <= sd_req.init | bus.data[7];
                        end
                        msx_cart_pkg::SDC_SADDR:         sd_req.sector[7:0]   <= bus.data;
                        msx_cart_pkg::SDC_SADDR + 16'd1: sd_req.sector[15:8]  <= bus.data;
                        msx_cart_pkg::SDC_SADDR + 16'd2: sd_req.sector[23:16] <= bus.data;
                        msx_cart_pkg::SDC_SADDR + 16'd3: sd_req.sector[31:24] <= bus.data;
                        default: ;  // read-only or unused
                    endcase
                end
            end
        end
    end

endmodule

//--- mux_bus_sampler.sv
`timescale 1ns/1ns

module mux_bus_sampler (
    input  logic                   clk108_w,
    input  logic                   ram_enabled_w,
    input  logic [7:0]             mp,
    input  logic                   rd_n,
    input  logic                   wr_n,
    input  logic                   sltsl_n,
    input  logic [7:0]             cd_in,
    output logic [2:0]             msel_n,
    output msx_cart_pkg::cpu_bus_t bus,
    output logic                   bus_strobe
);

    logic [2:0]              state;
    logic                    dotena;   // second clock of a select code
    msx_cart_pkg::mux_byte_u pin_w;
    msx_cart_pkg::mux_byte_u addr_lo;
    msx_cart_pkg::mux_byte_u addr_hi;

    assign pin_w = mp;

    ////////////////////
    // select sequencer
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state  <= '0;
            msel_n <= msx_cart_pkg::MSEL_NONE;
            dotena <= 1'b0;
        end else begin
            dotena <= state[0];  // odd states hold the code
            case (state)
                3'd0: msel_n <= msx_cart_pkg::MSEL_LOW;
                3'd2: msel_n <= msx_cart_pkg::MSEL_HIGH;
                3'd4: msel_n <= msx_cart_pkg::MSEL_CTRL;
                3'd6: msel_n <= msx_cart_pkg::MSEL_NONE;
                default: ;
            endcase
            if (state == 3'(msx_cart_pkg::BUS_FRAME - 1))
                state <= '0;
            else
                state <= state + 3'd1;
        end
    end

    // pin capture, the frame is published with the control byte
    always_ff @(posedge clk108_w) begin
        if (dotena) begin
            case (msel_n)
                msx_cart_pkg::MSEL_LOW:  addr_lo <= pin_w;
                msx_cart_pkg::MSEL_HIGH: addr_hi <= pin_w;
                msx_cart_pkg::MSEL_CTRL: begin
                    bus.addr    <= {addr_hi.raw, addr_lo.raw};
                    bus.data    <= cd_in;
                    bus.merq_n  <= pin_w.ctrl.merq_n;
                    bus.iorq_n  <= pin_w.ctrl.iorq_n;
                    bus.m1_n    <= pin_w.ctrl.m1_n;
                    bus.rd_n    <= rd_n;
                    bus.wr_n    <= wr_n;
                    bus.sltsl_n <= sltsl_n;
                    bus.spare   <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            bus_strobe <= 1'b0;
        else
            bus_strobe <= dotena && (msel_n == msx_cart_pkg::MSEL_CTRL);
    end

endmodule

//--- msx_cart_pkg.sv
package msx_cart_pkg;

    ////////////////////
    // bus multiplexer select codes, active low
    localparam logic [2:0] MSEL_LOW  = 3'b110;  // a0-a7
    localparam logic [2:0] MSEL_HIGH = 3'b101;  // a8-a15
    localparam logic [2:0] MSEL_CTRL = 3'b011;  // merq, iorq, cs, rfsh, m1
    localparam logic [2:0] MSEL_NONE = 3'b111;

    localparam int BUS_FRAME = 7;  // clocks per sampled bus cycle

    ////////////////////
    // sd host window
    localparam logic [15:0] SDC_SDATA     = 16'h7C00;  // sector transfer area
    localparam logic [15:0] SDC_SDATA_END = 16'h7DFF;
    localparam logic [15:0] SDC_ENABLE    = 16'h7E00;  // bit 0 opens the window
    localparam logic [15:0] SDC_CMD       = 16'h7E01;  // 1 read, 2 write, 80h init
    localparam logic [15:0] SDC_STATUS    = 16'h7E02;
    localparam logic [15:0] SDC_SADDR     = 16'h7E03;  // 4 bytes, lsb first
    localparam logic [15:0] SDC_CTYPE     = 16'h7E0C;
    localparam logic [15:0] SDC_END       = 16'h7EFF;

    localparam int SECTOR_BYTES = 512;

    ////////////////////
    // mapper config port and its codes
    localparam logic [7:0] CFG_PORT       = 8'h8F;
    localparam logic [7:0] CFG_KONAMI_SCC = 8'h05;
    localparam logic [7:0] CFG_ASCII16    = 8'h16;
    localparam logic [7:0] CFG_ASCII8     = 8'h08;
    localparam logic [7:0] CFG_KONAMI     = 8'h04;

    localparam logic [1:0] MR_KONAMI  = 2'd0;
    localparam logic [1:0] MR_SCC     = 2'd1;
    localparam logic [1:0] MR_ASCII16 = 2'd2;
    localparam logic [1:0] MR_ASCII8  = 2'd3;

    // control byte as it sits on mp during MSEL_CTRL
    typedef struct packed {
        logic m1_n;
        logic cs12_n;
        logic rfsh_n;
        logic res_n;
        logic cs2_n;
        logic cs1_n;
        logic iorq_n;
        logic merq_n;
    } ctrl_byte_t;

    typedef union packed {
        logic [7:0] raw;   // address byte
        ctrl_byte_t ctrl;
    } mux_byte_u;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        merq_n;
        logic        iorq_n;
        logic        m1_n;
        logic        rd_n;
        logic        wr_n;
        logic        sltsl_n;
        logic        spare;
    } cpu_bus_t;

    typedef struct packed {
        logic       hit;
        logic [7:0] data;
    } slave_resp_t;

    typedef struct packed {
        logic        read_start;
        logic        write_start;
        logic        init;
        logic [31:0] sector;
    } sd_req_t;

    typedef struct packed {
        logic       busy;
        logic       done;   // one clock wide
        logic       crc_error;
        logic       timeout_error;
        logic [1:0] card_type;
    } sd_stat_t;

    typedef struct packed {
        logic [1:0] megaram_type;
        logic       scc_enable;
    } mapper_cfg_t;

endpackage
